/* Bender.yml */
package:
  name: soc_bus

sources:
  - source/dbus_pkg.sv
  - source/dbus.sv
  - source/sram_ctrl.sv
  - source/flash_array.sv
  - source/uart_regs.sv
  - source/soc_bus_top.sv
  - target: test
    files:
      - bench/soc_bus_tb.sv

/* bench/soc_bus_tb.sv */
`timescale 1ns/1ps

module soc_bus_tb import dbus_pkg::*; ();

    logic        clk;
    logic        arst_n;
    dbus_req_t   req;
    logic [31:0] rddata;
    logic        uart_tx;

    logic [31:0] lfsr_q = 32'hfb4e;
    logic [31:0] ram_model [MEM_WORDS];
    logic [3:0]  ram_valid [MEM_WORDS];
    logic [31:0] flash_model [MEM_WORDS];
    logic        flash_used [MEM_WORDS];
    logic [7:0]  ram_idx_q [$];
    logic [7:0]  flash_idx_q [$];
    logic [7:0]  tx_bytes_q [$];
    int          uart_div;
    int          errors;
    int          test_errors;
    int          tests;
    int          failed_tests;

    soc_bus_top dut0 (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .req_i     (req),
        .rddata_o  (rddata),
        .uart_tx_o (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    function automatic dbus_target_e decode_target(input logic [31:0] addr);
        if (addr[31:24] == RAM_BASE_HI) return TGT_RAM;
        if (addr[31:24] == FLASH_BASE_HI) return TGT_FLASH;
        if (addr[31:4] == UART_BASE) return TGT_UART;
        return TGT_NONE;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("error %s: expected %08h, actual %08h", test, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string test, input string what);
        $display("%s: %s", test, what);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string test);
        tests++;
        if (test_errors != 0) failed_tests++;
        $display("test %s finished with %0d errors", test, test_errors);
        test_errors = 0;
    endtask

    // each call drives one access just after the edge and releases it after the next one
    task automatic bus_access(input logic [31:0] addr, input logic [3:0] be, input logic rd,
                              input logic wr, input logic [31:0] data,
                              output logic [31:0] rdata);
        @(posedge clk);
        #1;
        req.address    = addr;
        req.byteenable = be;
        req.read       = rd;
        req.write      = wr;
        req.wrdata     = data;
        @(negedge clk);
        rdata = rddata;
        @(posedge clk);
        #1;
        req.read  = 1'b0;
        req.write = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        logic [31:0] ignored;
        bus_access(addr, be, 1'b0, 1'b1, data, ignored);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        bus_access(addr, 4'hf, 1'b1, 1'b0, 32'h0, rdata);
    endtask

    task automatic wait_tx_idle(input string test, output logic [31:0] status);
        int polls;
        polls = 0;
        bus_read({UART_BASE, UART_OFS_STATUS}, status);
        while (status[0] !== 1'b0 && polls < 500) begin
            bus_read({UART_BASE, UART_OFS_STATUS}, status);
            polls++;
        end
        if (status[0] !== 1'b0) report_failure(test, "uart busy bit never cleared");
    endtask

    ////////////////////
    // serial decoder
    ////////////////////

    task automatic receive_frame(input string test, output logic [7:0] data, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        data = 8'h0;
        @(negedge clk);
        while (uart_tx !== 1'b0 && waited < 4000) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx !== 1'b0) begin
            report_failure(test, "no start bit seen on uart_tx_o");
            return;
        end
        // first low sample is half a clock into the start bit
        repeat (uart_div + uart_div / 2 - 1) @(negedge clk);
        for (int k = 0; k < 8; k++) begin
            data[k] = uart_tx;
            repeat (uart_div) @(negedge clk);
        end
        if (uart_tx !== 1'b1) report_mismatch(test, 32'h1, {31'h0, uart_tx});
        ok = 1'b1;
    endtask

    task automatic watch_line_idle(input string test, input int cycles);
        int lows;
        lows = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (uart_tx !== 1'b1) lows++;
        end
        if (lows != 0) report_failure(test, "a second frame appeared on uart_tx_o");
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic exercise_ram();
        logic [31:0] hi;
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] m;
        logic [7:0]  idx;
        logic [3:0]  be;
        for (int i = 0; i < 200; i++) begin
            hi = rand_bits(14);
            if (ram_idx_q.size() == 0 || rand_bits(1) == 32'h1) begin
                idx  = 8'(rand_bits(8));
                be   = 4'(rand_bits(4));
                data = rand_bits(32);
                bus_write({RAM_BASE_HI, hi[13:0], idx, 2'b00}, be, data);
                m = byte_mask(be);
                ram_model[idx] = (ram_model[idx] & ~m) | (data & m);
                if (ram_valid[idx] == 4'h0 && be != 4'h0) ram_idx_q.push_back(idx);
                ram_valid[idx] = ram_valid[idx] | be;
            end else begin
                idx = ram_idx_q[rand_bits(8) % ram_idx_q.size()];
                bus_read({RAM_BASE_HI, hi[13:0], idx, 2'b00}, rd);
                // bytes never written stay undefined, so only written ones count
                m = byte_mask(ram_valid[idx]);
                if ((rd & m) !== (ram_model[idx] & m))
                    report_mismatch("ram_rw", ram_model[idx] & m, rd & m);
            end
        end
        finish_test("ram_rw");
    endtask

    task automatic program_flash();
        logic [31:0] hi;
        logic [31:0] data;
        logic [31:0] rd;
        logic [7:0]  idx;
        logic [3:0]  be;
        for (int i = 0; i < 20; i++) begin
            idx = 8'(rand_bits(8));
            bus_read({FLASH_BASE_HI, 14'h0, idx, 2'b00}, rd);
            if (rd !== 32'hffffffff) report_mismatch("flash_program", 32'hffffffff, rd);
        end
        for (int i = 0; i < 150; i++) begin
            hi  = rand_bits(14);
            idx = 8'(rand_bits(8));
            if (rand_bits(1) == 32'h1) begin
                be   = 4'(rand_bits(4));
                data = rand_bits(32);
                bus_write({FLASH_BASE_HI, hi[13:0], idx, 2'b00}, be, data);
                flash_model[idx] = flash_model[idx] & (data | ~byte_mask(be));
                if (!flash_used[idx]) flash_idx_q.push_back(idx);
                flash_used[idx] = 1'b1;
            end else begin
                bus_read({FLASH_BASE_HI, hi[13:0], idx, 2'b00}, rd);
                if (rd !== flash_model[idx])
                    report_mismatch("flash_program", flash_model[idx], rd);
            end
        end
        finish_test("flash_program");
    endtask

    task automatic probe_unmapped();
        logic [31:0] addr;
        logic [31:0] rd;
        logic [31:0] m;
        logic [7:0]  idx;
        for (int i = 0; i < 40; i++) begin
            addr = rand_bits(32);
            while (decode_target(addr) != TGT_NONE) addr = rand_bits(32);
            if (i % 2 == 0) begin
                bus_write(addr, 4'hf, rand_bits(32));
            end else begin
                bus_read(addr, rd);
                if (rd !== 32'h0) report_mismatch("unmapped", 32'h0, rd);
            end
        end
        for (int k = 0; k < ram_idx_q.size(); k++) begin
            idx = ram_idx_q[k];
            m   = byte_mask(ram_valid[idx]);
            bus_read({RAM_BASE_HI, 14'h0, idx, 2'b00}, rd);
            if ((rd & m) !== (ram_model[idx] & m))
                report_mismatch("unmapped", ram_model[idx] & m, rd & m);
        end
        for (int k = 0; k < flash_idx_q.size(); k++) begin
            idx = flash_idx_q[k];
            bus_read({FLASH_BASE_HI, 14'h0, idx, 2'b00}, rd);
            if (rd !== flash_model[idx]) report_mismatch("unmapped", flash_model[idx], rd);
        end
        finish_test("unmapped");
    endtask

    task automatic send_uart_frames();
        logic [31:0] rd;
        logic [31:0] status;
        logic [7:0]  tx_byte;
        logic [7:0]  rx_byte;
        logic [7:0]  exp;
        logic        ok;
        bus_read({UART_BASE, UART_OFS_DIV}, rd);
        if (rd !== 32'(UART_DIV_RESET)) report_mismatch("uart_frames", 32'(UART_DIV_RESET), rd);
        uart_div = 4 + rand_bits(4);
        bus_write({UART_BASE, UART_OFS_DIV}, 4'h3, 32'(uart_div));
        bus_read({UART_BASE, UART_OFS_DIV}, rd);
        if (rd !== 32'(uart_div)) report_mismatch("uart_frames", 32'(uart_div), rd);
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    wait_tx_idle("uart_frames", status);
                    tx_byte = 8'(rand_bits(8));
                    tx_bytes_q.push_back(tx_byte);
                    bus_write({UART_BASE, UART_OFS_DATA}, 4'h1, {24'h0, tx_byte});
                end
            end
            begin
                for (int i = 0; i < 6; i++) begin
                    receive_frame("uart_frames", rx_byte, ok);
                    if (!ok) break;
                    if (tx_bytes_q.size() == 0) begin
                        report_failure("uart_frames", "frame received with no byte written");
                    end else begin
                        exp = tx_bytes_q.pop_front();
                        if (rx_byte !== exp) report_mismatch("uart_frames", exp, rx_byte);
                    end
                end
            end
        join
        finish_test("uart_frames");
    endtask

    task automatic check_uart_status();
        logic [31:0] rd;
        logic [31:0] status;
        logic [7:0]  first;
        logic [7:0]  rx_byte;
        logic        ok;
        first = 8'(rand_bits(8));
        // this read also clears done left over from the previous test
        wait_tx_idle("uart_status", status);
        fork
            begin
                bus_write({UART_BASE, UART_OFS_DATA}, 4'h1, {24'h0, first});
                bus_read({UART_BASE, UART_OFS_STATUS}, rd);
                if (rd[0] !== 1'b1) report_mismatch("uart_status", 32'h1, {31'h0, rd[0]});
                bus_write({UART_BASE, UART_OFS_DATA}, 4'h1, {24'h0, ~first});
                wait_tx_idle("uart_status", status);
                if (status[1] !== 1'b1) report_mismatch("uart_status", 32'h2, status & 32'h2);
                bus_read({UART_BASE, UART_OFS_STATUS}, rd);
                if (rd[1] !== 1'b0) report_mismatch("uart_status", 32'h0, rd & 32'h2);
            end
            begin
                receive_frame("uart_status", rx_byte, ok);
                if (ok && rx_byte !== first) report_mismatch("uart_status", first, rx_byte);
                if (ok) watch_line_idle("uart_status", 12 * uart_div);
            end
        join
        finish_test("uart_status");
    endtask

    task automatic read_uart_hole();
        logic [31:0] rd;
        bus_read({UART_BASE, 4'hc}, rd);
        if (rd !== 32'h0) report_mismatch("uart_window", 32'h0, rd);
        finish_test("uart_window");
    endtask

    initial begin
        arst_n       = 1'b0;
        req          = '0;
        errors       = 0;
        test_errors  = 0;
        tests        = 0;
        failed_tests = 0;
        uart_div     = UART_DIV_RESET;
        for (int w = 0; w < MEM_WORDS; w++) begin
            ram_model[w]   = '0;
            ram_valid[w]   = 4'h0;
            flash_model[w] = '1;
            flash_used[w]  = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        exercise_ram();
        program_flash();
        probe_unmapped();
        send_uart_frames();
        check_uart_status();
        read_uart_hole();

        $display("summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* soc_bus.f */
source/dbus_pkg.sv
source/dbus.sv
source/sram_ctrl.sv
source/flash_array.sv
source/uart_regs.sv
source/soc_bus_top.sv
bench/soc_bus_tb.sv

/* source/dbus.sv */
`timescale 1ns/1ps

module dbus import dbus_pkg::*; (
    input  dbus_req_t   req_i,
    output logic [31:0] rddata_o,

    output dev_req_t    ram_req_o,
    output dev_req_t    flash_req_o,
    output dev_req_t    uart_req_o,

    input  logic [31:0] ram_rddata_i,
    input  logic [31:0] flash_rddata_i,
    input  logic [31:0] uart_rddata_i
);

    dbus_target_e target;
    dev_req_t     bcast;

    ////////////////////
    // decode
    ////////////////////

    // ram wins over flash, flash over the uart window
    always_comb begin
        if (req_i.address[31:24] == RAM_BASE_HI) begin
            target = TGT_RAM;
        end else if (req_i.address[31:24] == FLASH_BASE_HI) begin
            target = TGT_FLASH;
        end else if (req_i.address[31:4] == UART_BASE) begin
            target = TGT_UART;
        end else begin
            target = TGT_NONE;
        end
    end

    // address, data and byte enables go to every target
    assign bcast.address    = req_i.address[23:0];
    assign bcast.data       = req_i.wrdata;
    assign bcast.byteenable = req_i.byteenable;
    assign bcast.rd         = 1'b0;
    assign bcast.wr         = 1'b0;

    ////////////////////
    // strobes and read mux
    ////////////////////

    always_comb begin
        ram_req_o   = bcast;
        flash_req_o = bcast;
        uart_req_o  = bcast;
        rddata_o    = 32'h0;

        case (target)
            TGT_RAM: begin
                ram_req_o.rd = req_i.read;
                ram_req_o.wr = req_i.write;
                rddata_o     = ram_rddata_i;
            end
            TGT_FLASH: begin
                flash_req_o.rd = req_i.read;
                flash_req_o.wr = req_i.write;
                rddata_o       = flash_rddata_i;
            end
            TGT_UART: begin
                uart_req_o.rd = req_i.read;
                uart_req_o.wr = req_i.write;
                rddata_o      = uart_rddata_i;
            end
            default: begin
                // unmapped accesses read zero and touch nothing
                rddata_o = 32'h0;
            end
        endcase
    end

endmodule

/* source/dbus_pkg.sv */
package dbus_pkg;

    ////////////////////
    // address map
    ////////////////////

    localparam logic [7:0]  RAM_BASE_HI   = 8'h00;
    localparam logic [7:0]  FLASH_BASE_HI = 8'hbe;
    localparam logic [27:0] UART_BASE     = 28'h1fd003f;

    // ram and flash share one word count, indexed by address bits 9 to 2
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    ////////////////////
    // uart registers
    ////////////////////

    localparam logic [3:0]  UART_OFS_DATA   = 4'h0;
    localparam logic [3:0]  UART_OFS_STATUS = 4'h4;
    localparam logic [3:0]  UART_OFS_DIV    = 4'h8;
    localparam logic [15:0] UART_DIV_RESET  = 16'd16;

    ////////////////////
    // bus types
    ////////////////////

    typedef struct packed {
        logic [31:0] address;
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
        logic [31:0] wrdata;
    } dbus_req_t;

    // the uart looks only at the low 4 address bits
    typedef struct packed {
        logic [23:0] address;
        logic [31:0] data;
        logic [3:0]  byteenable;
        logic        rd;
        logic        wr;
    } dev_req_t;

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_FLASH,
        TGT_UART
    } dbus_target_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_state_e;

endpackage

/* source/flash_array.sv */
`timescale 1ns/1ps

module flash_array import dbus_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  dev_req_t    req_i,
    output logic [31:0] rddata_o
);

    logic [31:0]       mem [MEM_WORDS];
    logic [MEM_AW-1:0] idx;

    assign idx = req_i.address[MEM_AW+1:2];

    ////////////////////
    // program
    ////////////////////

    // an erased array reads all ones, and programming can only clear bits
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '1;
            end
        end else if (req_i.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.byteenable[b]) begin
                    mem[idx][8*b +: 8] <= mem[idx][8*b +: 8] & req_i.data[8*b +: 8];
                end
            end
        end
    end

    ////////////////////
    // read
    ////////////////////

    always_comb begin
        if (req_i.rd) begin
            rddata_o = mem[idx];
        end else begin
            rddata_o = 32'h0;
        end
    end

endmodule

/* source/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top import dbus_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  dbus_req_t   req_i,
    output logic [31:0] rddata_o,
    output logic        uart_tx_o
);

    dev_req_t    ram_req;
    dev_req_t    flash_req;
    dev_req_t    uart_req;
    logic [31:0] ram_rddata;
    logic [31:0] flash_rddata;
    logic [31:0] uart_rddata;

    dbus u_dbus (
        .req_i          (req_i),
        .rddata_o       (rddata_o),
        .ram_req_o      (ram_req),
        .flash_req_o    (flash_req),
        .uart_req_o     (uart_req),
        .ram_rddata_i   (ram_rddata),
        .flash_rddata_i (flash_rddata),
        .uart_rddata_i  (uart_rddata)
    );

    sram_ctrl u_sram (
        .clk_i    (clk_i),
        .req_i    (ram_req),
        .rddata_o (ram_rddata)
    );

    flash_array u_flash (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (flash_req),
        .rddata_o (flash_rddata)
    );

    uart_regs u_uart (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (uart_req),
        .rddata_o (uart_rddata),
        .tx_o     (uart_tx_o)
    );

endmodule

/* source/sram_ctrl.sv */
`timescale 1ns/1ps

module sram_ctrl import dbus_pkg::*; (
    input  logic        clk_i,
    input  dev_req_t    req_i,
    output logic [31:0] rddata_o
);

    logic [31:0]       mem [MEM_WORDS];
    logic [MEM_AW-1:0] idx;

    // higher offset bits inside the region alias onto the same words
    assign idx = req_i.address[MEM_AW+1:2];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (req_i.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.byteenable[b]) begin
                    mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
                end
            end
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // asynchronous read of the indexed word
    always_comb begin
        if (req_i.rd) begin
            rddata_o = mem[idx];
        end else begin
            rddata_o = 32'h0;
        end
    end

endmodule

/* source/uart_regs.sv */
`timescale 1ns/1ps

module uart_regs import dbus_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  dev_req_t    req_i,
    output logic [31:0] rddata_o,
    output logic        tx_o
);

    uart_state_e state_q;
    logic [3:0]  ofs;
    logic        data_wr;
    logic        div_wr;
    logic        status_rd;
    logic        busy;
    logic        done_q;
    logic        tx_q;
    logic        tx_start;
    logic        bit_end;
    logic [15:0] divisor_q;
    logic [15:0] bit_div_q;
    logic [15:0] baud_cnt_q;
    logic [2:0]  bit_cnt_q;
    logic [7:0]  shift_q;

    ////////////////////
    // register decode
    ////////////////////

    assign ofs       = req_i.address[3:0];
    assign data_wr   = req_i.wr && (ofs == UART_OFS_DATA);
    assign div_wr    = req_i.wr && (ofs == UART_OFS_DIV);
    assign status_rd = req_i.rd && (ofs == UART_OFS_STATUS);

    assign busy     = (state_q != TX_IDLE);
    // a data write while a frame is in flight is dropped
    assign tx_start = data_wr && !busy;
    assign bit_end  = busy && (baud_cnt_q == 16'h0);

    always_comb begin
        rddata_o = 32'h0;
        if (req_i.rd) begin
            case (ofs)
                UART_OFS_STATUS: rddata_o = {30'h0, done_q, busy};
                UART_OFS_DIV:    rddata_o = {16'h0, divisor_q};
                default:         rddata_o = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            divisor_q <= UART_DIV_RESET;
        end else if (div_wr) begin
            if (req_i.byteenable[0]) divisor_q[7:0]  <= req_i.data[7:0];
            if (req_i.byteenable[1]) divisor_q[15:8] <= req_i.data[15:8];
        end
    end

    ////////////////////
    // transmitter
    ////////////////////

    // the divisor is sampled once per frame so a mid-frame write waits
    always_ff @(posedge clk_i) begin
        if (tx_start) begin
            shift_q   <= req_i.data[7:0];
            bit_div_q <= divisor_q;
        end else if (bit_end && state_q != TX_STOP) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= TX_IDLE;
            tx_q       <= 1'b1;
            done_q     <= 1'b0;
            baud_cnt_q <= 16'h0;
            bit_cnt_q  <= 3'h0;
        end else begin
            if (busy && !bit_end) begin
                baud_cnt_q <= baud_cnt_q - 16'h1;
            end
            case (state_q)
                TX_IDLE: begin
                    if (tx_start) begin
                        state_q    <= TX_START;
                        tx_q       <= 1'b0;
                        baud_cnt_q <= divisor_q - 16'h1;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state_q    <= TX_DATA;
                        tx_q       <= shift_q[0];
                        bit_cnt_q  <= 3'h0;
                        baud_cnt_q <= bit_div_q - 16'h1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        baud_cnt_q <= bit_div_q - 16'h1;
                        if (bit_cnt_q == 3'h7) begin
                            state_q <= TX_STOP;
                            tx_q    <= 1'b1;
                        end else begin
                            tx_q      <= shift_q[0];
                            bit_cnt_q <= bit_cnt_q + 3'h1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase

            // setting done in the same cycle wins over the clear on read
            if (state_q == TX_STOP && bit_end) begin
                done_q <= 1'b1;
            end else if (status_rd) begin
                done_q <= 1'b0;
            end
        end
    end

    assign tx_o = tx_q;

endmodule
